//--- src.f
soc_pkg.sv
data_ram.sv
plic_core.sv
bus_front.sv
board_soc.sv
board_soc_checker.sv
tb_board_soc.sv

//--- Makefile
SIM := obj_dir/Vtb_board_soc

$(SIM): src.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_board_soc -f src.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- tb_board_soc.sv
`timescale 1ns/1ps

module tb_board_soc import soc_pkg::*; ();

    localparam int RAM_WORDS   = 1024;
    localparam int NUM_SOURCES = 5;
    // about 60 bus accesses in all, 10 cycles each plus room for idle gaps
    localparam int ACCESS_COUNT    = 61;
    localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 10 + 200;

    logic                   CLOCK_50;
    logic                   KEY0;
    addr_t                  bus_addr;
    data_t                  bus_wdata;
    ls_type_t               bus_ls_type;
    logic                   bus_rd_en;
    logic                   bus_wr_en;
    logic [NUM_SOURCES-1:0] irq_src;
    data_t                  bus_rdata;
    logic                   bus_rd_done;
    logic                   bus_wr_done;
    logic                   meip;
    logic                   seip;

    // reference state
    word_t                ram_m [RAM_WORDS];
    logic [NUM_SOURCES:1] pend_m;
    prio_t                prio_m [1:NUM_SOURCES];
    logic [NUM_SOURCES:1] en_m [NUM_CONTEXTS];
    prio_t                thr_m [NUM_CONTEXTS];

    int seed     = 60284;
    int test_err = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    board_soc #(.RAM_WORDS(RAM_WORDS), .NUM_SOURCES(NUM_SOURCES)) dut0 (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_ls_type(bus_ls_type), .bus_rd_en(bus_rd_en), .bus_wr_en(bus_wr_en),
        .irq_src(irq_src), .bus_rdata(bus_rdata), .bus_rd_done(bus_rd_done),
        .bus_wr_done(bus_wr_done), .meip(meip), .seip(seip)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    // byte-lane merge into the word model
    function automatic void model_store(addr_t a, ls_type_t t, data_t d);
        int w;
        int b;
        w = int'((a - RAM_BASE) >> 2);
        b = int'(a[1:0]);
        case (t)
            LS_B:    ram_m[w][8*b +: 8] = d[7:0];
            LS_H:    ram_m[w][8*b +: 16] = d[15:0];
            LS_W:    ram_m[w] = d[31:0];
            default: begin
                ram_m[w]     = d[31:0];
                ram_m[w + 1] = d[63:32];
            end
        endcase
    endfunction

    function automatic data_t model_load(addr_t a, ls_type_t t);
        int    w;
        word_t sh;
        w  = int'((a - RAM_BASE) >> 2);
        // addressed lane down to bit 0
        sh = ram_m[w] >> (8 * int'(a[1:0]));
        case (t)
            LS_B:    return {{56{sh[7]}}, sh[7:0]};
            LS_H:    return {{48{sh[15]}}, sh[15:0]};
            LS_W:    return {{32{ram_m[w][31]}}, ram_m[w]};
            LS_BU:   return {56'd0, sh[7:0]};
            LS_HU:   return {48'd0, sh[15:0]};
            LS_WU:   return {32'd0, ram_m[w]};
            default: return {ram_m[w + 1], ram_m[w]};
        endcase
    endfunction

    // highest priority above threshold, lowest id on a tie
    function automatic irq_id_t model_winner(int c);
        prio_t   best;
        irq_id_t id;
        best = thr_m[c];
        id   = '0;
        for (int s = NUM_SOURCES; s >= 1; s--) begin
            if (pend_m[s] && en_m[c][s] && prio_m[s] > thr_m[c] && prio_m[s] >= best) begin
                best = prio_m[s];
                id   = irq_id_t'(s);
            end
        end
        return id;
    endfunction

    task automatic check_val(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge CLOCK_50);
    endtask

    // one request, enable for a single cycle, then wait for done
    task automatic bus_access(input logic wr, input addr_t a, input ls_type_t t,
                              input data_t wd, output data_t rd);
        logic done_seen;
        done_seen = 1'b0;
        @(posedge CLOCK_50);
        bus_addr    <= a;
        bus_ls_type <= t;
        bus_wdata   <= wd;
        bus_rd_en   <= !wr;
        bus_wr_en   <= wr;
        @(posedge CLOCK_50);
        bus_rd_en <= 1'b0;
        bus_wr_en <= 1'b0;
        for (int i = 0; i < 20 && !done_seen; i++) begin
            @(posedge CLOCK_50);
            done_seen = wr ? bus_wr_done : bus_rd_done;
        end
        rd = bus_rdata;
        assert (done_seen) else begin
            $display("request to address %h did not complete within 20 cycles", a);
            test_err++;
        end
    endtask

    task automatic bus_write(input addr_t a, input ls_type_t t, input data_t d);
        data_t unused;
        bus_access(1'b1, a, t, d, unused);
    endtask

    task automatic read_check(input string name, input addr_t a, input ls_type_t t,
                              input data_t exp);
        data_t rd;
        bus_access(1'b0, a, t, '0, rd);
        check_val(name, exp, rd);
    endtask

    // irq_src[0] is source id 1
    task automatic pulse_sources(input logic [NUM_SOURCES-1:0] mask);
        @(posedge CLOCK_50);
        irq_src <= mask;
        @(posedge CLOCK_50);
        irq_src <= '0;
        pend_m = pend_m | mask;
        idle(3);
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("test %s: passed", name);
            pass_cnt++;
        end else begin
            $display("test %s: failed with %0d errors", name, test_err);
            fail_cnt++;
        end
        test_err = 0;
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        addr_t addrs [4];
        addr_t base;
        data_t d;
        addr_t claim0;
        addr_t claim1;
        irq_id_t exp_id;
        CLOCK_50    = 1'b0;
        KEY0        = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        bus_ls_type = LS_W;
        bus_rd_en   = 1'b0;
        bus_wr_en   = 1'b0;
        irq_src     = '0;
        pend_m      = '0;
        claim0      = PLIC_BASE + PLIC_CLAIM_OFS;
        claim1      = PLIC_BASE + PLIC_CLAIM_OFS + PLIC_CTX_STRIDE;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // random words, spread over the ram
        for (int i = 0; i < 4; i++) begin
            addrs[i] = RAM_BASE + addr_t'(4 * (i * 37 + 3));
            d = data_t'($random(seed));
            bus_write(addrs[i], LS_W, d);
            model_store(addrs[i], LS_W, d);
        end
        for (int i = 0; i < 4; i++) begin
            read_check($sformatf("lw %0d", i), addrs[i], LS_W, model_load(addrs[i], LS_W));
            read_check($sformatf("lwu %0d", i), addrs[i], LS_WU, model_load(addrs[i], LS_WU));
        end
        finish_test("word round trip");

        base = RAM_BASE + 32'h100;
        d = data_t'($random(seed));
        bus_write(base, LS_W, d);
        model_store(base, LS_W, d);
        d = data_t'($random(seed));
        bus_write(base + 1, LS_B, d);
        model_store(base + 1, LS_B, d);
        d = data_t'($random(seed));
        bus_write(base + 2, LS_H, d);
        model_store(base + 2, LS_H, d);
        for (int off = 0; off < 4; off++) begin
            read_check($sformatf("lb ofs %0d", off), base + addr_t'(off), LS_B,
                       model_load(base + addr_t'(off), LS_B));
            read_check($sformatf("lbu ofs %0d", off), base + addr_t'(off), LS_BU,
                       model_load(base + addr_t'(off), LS_BU));
        end
        for (int off = 0; off < 4; off += 2) begin
            read_check($sformatf("lh ofs %0d", off), base + addr_t'(off), LS_H,
                       model_load(base + addr_t'(off), LS_H));
            read_check($sformatf("lhu ofs %0d", off), base + addr_t'(off), LS_HU,
                       model_load(base + addr_t'(off), LS_HU));
        end
        read_check("lw after merge", base, LS_W, model_load(base, LS_W));
        finish_test("sub-word stores");

        base = RAM_BASE + 32'h200;
        d = {$random(seed), $random(seed)};
        bus_write(base, LS_D, d);
        model_store(base, LS_D, d);
        read_check("ld", base, LS_D, d);
        read_check("lw low half", base, LS_W, model_load(base, LS_W));
        read_check("lw high half", base + 4, LS_W, model_load(base + 4, LS_W));
        finish_test("double access");

        // two equal top priorities to exercise the tie rule
        prio_m[1] = 3'd2;
        prio_m[2] = 3'd5;
        prio_m[3] = 3'd5;
        prio_m[4] = 3'd1;
        prio_m[5] = 3'd3;
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            bus_write(PLIC_BASE + addr_t'(4 * s), LS_W, data_t'(prio_m[s]));
        end
        en_m[0]  = '1;
        en_m[1]  = '0;
        thr_m[0] = 3'd2;
        thr_m[1] = 3'd0;
        bus_write(PLIC_BASE + PLIC_ENABLE_OFS, LS_W, data_t'({en_m[0], 1'b0}));
        bus_write(PLIC_BASE + PLIC_THRESHOLD_OFS, LS_W, data_t'(thr_m[0]));
        pulse_sources('1);
        check_val("meip after pulse", data_t'(model_winner(0) != '0), data_t'(meip));
        for (int k = 0; k < 4; k++) begin
            exp_id = model_winner(0);
            read_check($sformatf("claim %0d", k), claim0, LS_W, data_t'(exp_id));
            if (exp_id != '0) pend_m[exp_id] = 1'b0;
            read_check($sformatf("pending %0d", k), PLIC_BASE + PLIC_PENDING_OFS, LS_W,
                       data_t'({pend_m, 1'b0}));
            idle(2);
            check_val($sformatf("meip %0d", k), data_t'(model_winner(0) != '0), data_t'(meip));
        end
        finish_test("priority and threshold");

        // supervisor context only
        en_m[0]  = '0;
        en_m[1]  = '1;
        thr_m[0] = 3'd0;
        thr_m[1] = 3'd1;
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            bus_write(PLIC_BASE + PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE,
                      LS_W, data_t'({en_m[c], 1'b0}));
            bus_write(PLIC_BASE + PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE,
                      LS_W, data_t'(thr_m[c]));
        end
        pulse_sources(5'b00100);
        check_val("seip", data_t'(model_winner(1) != '0), data_t'(seip));
        check_val("meip stays low", 64'd0, data_t'(meip));
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            read_check($sformatf("enable ctx %0d", c),
                       PLIC_BASE + PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE,
                       LS_W, data_t'({en_m[c], 1'b0}));
            read_check($sformatf("threshold ctx %0d", c),
                       PLIC_BASE + PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE,
                       LS_W, data_t'(thr_m[c]));
        end
        exp_id = model_winner(1);
        read_check("claim ctx 1", claim1, LS_W, data_t'(exp_id));
        if (exp_id != '0) pend_m[exp_id] = 1'b0;
        finish_test("context separation");

        read_check("unmapped read", 32'h8000_0000, LS_W, 64'd0);
        // just past each window so a wrapped decode would hit word 3 and priority 2
        bus_write(RAM_BASE + addr_t'(4 * RAM_WORDS) + (addrs[0] - RAM_BASE), LS_W,
                  data_t'($random(seed)));
        bus_write(PLIC_BASE + PLIC_SPAN + 32'h8, LS_W, 64'd7);
        read_check("ram after unmapped write", addrs[0], LS_W, model_load(addrs[0], LS_W));
        read_check("plic after unmapped write", PLIC_BASE + 32'h8, LS_W, data_t'(prio_m[2]));
        finish_test("unmapped access");

        $display("tests passed %0d, failed %0d, checker failures %0d",
                 pass_cnt, fail_cnt, dut0.chk0.assert_fails);
        if (fail_cnt == 0 && dut0.chk0.assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- board_soc_checker.sv
`timescale 1ns/1ps

module board_soc_checker import soc_pkg::*; #(
    parameter int RAM_WORDS   = 1024,
    parameter int NUM_SOURCES = 5
) (
    input logic                 CLOCK_50,
    input logic                 KEY0,
    input addr_t                bus_addr,
    input ls_type_t             bus_ls_type,
    input logic                 bus_rd_en,
    input logic                 bus_wr_en,
    input logic                 bus_rd_done,
    input logic                 bus_wr_done,
    input logic                 meip,
    input logic [NUM_SOURCES:1] ctx0_enable
);

    int   assert_fails = 0;
    logic mapped;
    logic short_rd;

    // ram or plic window
    assign mapped = ((bus_addr >= RAM_BASE) && (bus_addr < RAM_BASE + addr_t'(4 * RAM_WORDS)))
                 || ((bus_addr >= PLIC_BASE) && (bus_addr < PLIC_BASE + PLIC_SPAN));
    // single-cycle slave access, doubles take one more
    assign short_rd = bus_rd_en && mapped && (bus_ls_type != LS_D);

    done_at_release: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> (bus_rd_done && bus_wr_done))
        else begin
            $error("done flag low at reset release");
            assert_fails++;
        end

    rd_done_falls: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rd_en |=> !bus_rd_done)
        else begin
            $error("read done did not fall after read enable");
            assert_fails++;
        end

    wr_done_falls: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_wr_en |=> !bus_wr_done)
        else begin
            $error("write done did not fall after write enable");
            assert_fails++;
        end

    // enable at E, done rises on edge E+2
    short_rd_timing: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(short_rd, 3) |-> (bus_rd_done && !$past(bus_rd_done)))
        else begin
            $error("read done did not rise two cycles after enable");
            assert_fails++;
        end

    // meip registers the arbiter result of the previous cycle
    meip_needs_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(meip) |-> ($past(ctx0_enable) != '0))
        else begin
            $error("meip rose with no context 0 enable set");
            assert_fails++;
        end

endmodule

bind board_soc board_soc_checker #(
    .RAM_WORDS(RAM_WORDS),
    .NUM_SOURCES(NUM_SOURCES)
) chk0 (
    .CLOCK_50(CLOCK_50),
    .KEY0(KEY0),
    .bus_addr(bus_addr),
    .bus_ls_type(bus_ls_type),
    .bus_rd_en(bus_rd_en),
    .bus_wr_en(bus_wr_en),
    .bus_rd_done(bus_rd_done),
    .bus_wr_done(bus_wr_done),
    .meip(meip),
    .ctx0_enable(u_plic_core.enable[0])
);

//--- board_soc.sv
`timescale 1ns/1ps

module board_soc import soc_pkg::*; #(
    parameter int RAM_WORDS   = 1024,
    parameter int NUM_SOURCES = 5
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  addr_t                  bus_addr,
    input  data_t                  bus_wdata,
    input  ls_type_t               bus_ls_type,
    input  logic                   bus_rd_en,
    input  logic                   bus_wr_en,
    input  logic [NUM_SOURCES-1:0] irq_src,
    output data_t                  bus_rdata,
    output logic                   bus_rd_done,
    output logic                   bus_wr_done,
    output logic                   meip,
    output logic                   seip
);

    // front end to slaves
    logic  ram_sel;
    logic  plic_sel;
    logic  acc_rd;
    logic  acc_wr;
    // slave answers
    logic  ram_ack;
    logic  plic_ack;
    data_t ram_rdata;
    data_t plic_rdata;

    bus_front #(.RAM_WORDS(RAM_WORDS)) u_bus_front (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .bus_addr(bus_addr),
        .bus_rd_en(bus_rd_en), .bus_wr_en(bus_wr_en),
        .ram_ack(ram_ack), .ram_rdata(ram_rdata),
        .plic_ack(plic_ack), .plic_rdata(plic_rdata),
        .bus_rdata(bus_rdata), .bus_rd_done(bus_rd_done), .bus_wr_done(bus_wr_done),
        .ram_sel(ram_sel), .plic_sel(plic_sel), .acc_rd(acc_rd), .acc_wr(acc_wr)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .ram_sel(ram_sel),
        .acc_rd(acc_rd), .acc_wr(acc_wr), .bus_addr(bus_addr),
        .bus_ls_type(bus_ls_type), .bus_wdata(bus_wdata),
        .ram_ack(ram_ack), .ram_rdata(ram_rdata)
    );

    plic_core #(.NUM_SOURCES(NUM_SOURCES)) u_plic_core (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .plic_sel(plic_sel),
        .acc_rd(acc_rd), .acc_wr(acc_wr), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .irq_src(irq_src),
        .plic_ack(plic_ack), .plic_rdata(plic_rdata), .meip(meip), .seip(seip)
    );

endmodule

//--- bus_front.sv
`timescale 1ns/1ps

module bus_front import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  addr_t bus_addr,
    input  logic  bus_rd_en,
    input  logic  bus_wr_en,
    input  logic  ram_ack,
    input  data_t ram_rdata,
    input  logic  plic_ack,
    input  data_t plic_rdata,
    output data_t bus_rdata,
    output logic  bus_rd_done,
    output logic  bus_wr_done,
    output logic  ram_sel,
    output logic  plic_sel,
    output logic  acc_rd,
    output logic  acc_wr
);

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT_ACK, ST_FINISH} state_t;

    localparam addr_t RAM_END  = RAM_BASE + addr_t'(4 * RAM_WORDS);
    localparam addr_t PLIC_END = PLIC_BASE + PLIC_SPAN;

    state_t state;
    logic   op_rd;
    logic   ram_hit;
    logic   plic_hit;
    logic   slv_ack;
    data_t  slv_rdata;

    // window compares on the live address
    assign ram_hit  = (bus_addr >= RAM_BASE) && (bus_addr < RAM_END);
    assign plic_hit = (bus_addr >= PLIC_BASE) && (bus_addr < PLIC_END);

    // only the selected slave counts
    assign slv_ack   = (ram_sel && ram_ack) || (plic_sel && plic_ack);
    assign slv_rdata = ({64{ram_sel}} & ram_rdata) | ({64{plic_sel}} & plic_rdata);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state       <= ST_IDLE;
            op_rd       <= 1'b0;
            ram_sel     <= 1'b0;
            plic_sel    <= 1'b0;
            acc_rd      <= 1'b0;
            acc_wr      <= 1'b0;
            bus_rd_done <= 1'b1;
            bus_wr_done <= 1'b1;
            bus_rdata   <= '0;
        end else begin
            // strobes last one cycle
            acc_rd <= 1'b0;
            acc_wr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus_rd_en || bus_wr_en) begin
                        op_rd       <= bus_rd_en;
                        ram_sel     <= ram_hit;
                        plic_sel    <= plic_hit;
                        acc_rd      <= bus_rd_en;
                        acc_wr      <= !bus_rd_en;
                        bus_rd_done <= !bus_rd_en;
                        bus_wr_done <= bus_rd_en;
                        state       <= ST_ACCESS;
                    end
                end
                // nobody selected, answer locally
                ST_ACCESS: state <= (ram_sel || plic_sel) ? ST_WAIT_ACK : ST_FINISH;
                ST_WAIT_ACK: begin
                    if (slv_ack) begin
                        if (op_rd) bus_rdata <= slv_rdata;
                        bus_rd_done <= 1'b1;
                        bus_wr_done <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                default: begin
                    // unmapped reads return zero
                    if (op_rd) bus_rdata <= '0;
                    bus_rd_done <= 1'b1;
                    bus_wr_done <= 1'b1;
                    state       <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- plic_core.sv
`timescale 1ns/1ps

module plic_core import soc_pkg::*; #(
    parameter int NUM_SOURCES = 5
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   plic_sel,
    input  logic                   acc_rd,
    input  logic                   acc_wr,
    input  addr_t                  bus_addr,
    input  data_t                  bus_wdata,
    input  logic [NUM_SOURCES-1:0] irq_src,
    output logic                   plic_ack,
    output data_t                  plic_rdata,
    output logic                   meip,
    output logic                   seip
);

    // source ids run 1..NUM_SOURCES, irq_src[0] is id 1
    logic [NUM_SOURCES-1:0] src_q;
    logic [NUM_SOURCES-1:0] src_rise;
    logic [NUM_SOURCES:1]   pending;
    logic [NUM_SOURCES:1]   claim_clr;
    prio_t                  prio [1:NUM_SOURCES];
    logic [NUM_SOURCES:1]   enable [NUM_CONTEXTS];
    prio_t                  threshold [NUM_CONTEXTS];
    irq_id_t                win_id [NUM_CONTEXTS];
    prio_t                  run_max;
    addr_t                  ofs;
    logic                   hit_pending;
    logic [NUM_SOURCES:1]   hit_prio;
    logic [NUM_CONTEXTS-1:0] hit_enable;
    logic [NUM_CONTEXTS-1:0] hit_thresh;
    logic [NUM_CONTEXTS-1:0] hit_claim;
    word_t                  rd_val;

    assign ofs      = bus_addr - PLIC_BASE;
    // gateway, one cycle rising-edge pulse per source
    assign src_rise = irq_src & ~src_q;

    // register decode inside the window
    always_comb begin
        hit_pending = (ofs == PLIC_PENDING_OFS);
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            hit_prio[s] = (ofs == addr_t'(4 * s));
        end
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            hit_enable[c] = (ofs == PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE);
            hit_thresh[c] = (ofs == PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE);
            hit_claim[c]  = (ofs == PLIC_CLAIM_OFS + addr_t'(c) * PLIC_CTX_STRIDE);
        end
    end

    // per context, strictly above running max so ties keep the lower id
    always_comb begin
        run_max = '0;
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            run_max   = threshold[c];
            win_id[c] = '0;
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                if (pending[s] && enable[c][s] && prio[s] > run_max) begin
                    run_max   = prio[s];
                    win_id[c] = irq_id_t'(s);
                end
            end
        end
    end

    // claim read drops the winner's pending bit
    always_comb begin
        claim_clr = '0;
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                if (plic_sel && acc_rd && hit_claim[c] && win_id[c] == irq_id_t'(s)) begin
                    claim_clr[s] = 1'b1;
                end
            end
        end
    end

    // readback mux, bit 0 of pending and enable reads as zero
    always_comb begin
        rd_val = '0;
        if (hit_pending) begin
            rd_val = word_t'({pending, 1'b0});
        end
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            if (hit_prio[s]) rd_val = word_t'(prio[s]);
        end
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            if (hit_enable[c]) rd_val = word_t'({enable[c], 1'b0});
            if (hit_thresh[c]) rd_val = word_t'(threshold[c]);
            if (hit_claim[c])  rd_val = word_t'(win_id[c]);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (plic_sel && acc_rd) begin
            plic_rdata <= {32'd0, rd_val};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            src_q    <= '0;
            pending  <= '0;
            plic_ack <= 1'b0;
            meip     <= 1'b0;
            seip     <= 1'b0;
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                prio[s] <= '0;
            end
            for (int c = 0; c < NUM_CONTEXTS; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            src_q    <= irq_src;
            // a new edge wins over a claim in the same cycle
            pending  <= (pending & ~claim_clr) | src_rise;
            plic_ack <= plic_sel && (acc_rd || acc_wr);
            meip     <= (win_id[0] != '0);
            seip     <= (win_id[1] != '0);
            // pending and claim are read only
            if (plic_sel && acc_wr) begin
                for (int s = 1; s <= NUM_SOURCES; s++) begin
                    if (hit_prio[s]) prio[s] <= bus_wdata[2:0];
                end
                for (int c = 0; c < NUM_CONTEXTS; c++) begin
                    if (hit_enable[c]) enable[c] <= bus_wdata[NUM_SOURCES:1];
                    if (hit_thresh[c]) threshold[c] <= bus_wdata[2:0];
                end
            end
        end
    end

endmodule

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     ram_sel,
    input  logic     acc_rd,
    input  logic     acc_wr,
    input  addr_t    bus_addr,
    input  ls_type_t bus_ls_type,
    input  data_t    bus_wdata,
    output logic     ram_ack,
    output data_t    ram_rdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    typedef logic [IDX_W-1:0] idx_t;
    // second phase only used by double accesses
    typedef enum logic {PH_FIRST, PH_SECOND} phase_t;

    word_t  mem [RAM_WORDS];
    phase_t phase;
    logic   dbl_wr;
    addr_t  ram_ofs;
    idx_t   word_idx;
    idx_t   mem_idx;
    logic [1:0] byte_ofs;
    word_t  rd_word;
    word_t  rd_shift;
    data_t  load_val;
    logic [3:0] wr_be;
    word_t  wr_lanes;

    assign ram_ofs  = bus_addr - RAM_BASE;
    assign word_idx = ram_ofs[IDX_W+1:2];
    assign byte_ofs = ram_ofs[1:0];
    // high word of a double sits at the next index
    assign mem_idx  = (phase == PH_SECOND) ? idx_t'(word_idx + 1'b1) : word_idx;
    assign rd_word  = mem[mem_idx];
    // addressed byte or half moved down to bit 0
    assign rd_shift = rd_word >> (8 * byte_ofs);

    // sign or zero extension per load type
    always_comb begin
        case (bus_ls_type)
            LS_B:    load_val = {{56{rd_shift[7]}}, rd_shift[7:0]};
            LS_H:    load_val = {{48{rd_shift[15]}}, rd_shift[15:0]};
            LS_W:    load_val = {{32{rd_word[31]}}, rd_word};
            LS_BU:   load_val = {56'd0, rd_shift[7:0]};
            LS_HU:   load_val = {48'd0, rd_shift[15:0]};
            default: load_val = {32'd0, rd_word};
        endcase
    end

    // byte lanes for the store merge
    always_comb begin
        wr_be    = 4'b0000;
        wr_lanes = bus_wdata[31:0];
        if (phase == PH_SECOND) begin
            if (dbl_wr) begin
                wr_be    = 4'b1111;
                wr_lanes = bus_wdata[63:32];
            end
        end else if (ram_sel && acc_wr) begin
            case (bus_ls_type)
                LS_B: begin
                    wr_be    = 4'b0001 << byte_ofs;
                    wr_lanes = {4{bus_wdata[7:0]}};
                end
                LS_H: begin
                    wr_be    = byte_ofs[1] ? 4'b1100 : 4'b0011;
                    wr_lanes = {2{bus_wdata[15:0]}};
                end
                // word, or low half of a double
                LS_W, LS_D: wr_be = 4'b1111;
                default:    wr_be = 4'b0000;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        for (int b = 0; b < 4; b++) begin
            if (wr_be[b]) begin
                mem[mem_idx][8*b +: 8] <= wr_lanes[8*b +: 8];
            end
        end
    end

    // read data, low word first for a double
    always_ff @(posedge CLOCK_50) begin
        if (ram_sel && acc_rd) begin
            if (bus_ls_type == LS_D) begin
                ram_rdata[31:0] <= rd_word;
            end else begin
                ram_rdata <= load_val;
            end
        end else if (phase == PH_SECOND && !dbl_wr) begin
            ram_rdata[63:32] <= rd_word;
        end
    end

    // ack right away, or after the second word of a double
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            phase   <= PH_FIRST;
            dbl_wr  <= 1'b0;
            ram_ack <= 1'b0;
        end else begin
            ram_ack <= 1'b0;
            case (phase)
                PH_FIRST: begin
                    if (ram_sel && (acc_rd || acc_wr)) begin
                        if (bus_ls_type == LS_D) begin
                            phase  <= PH_SECOND;
                            dbl_wr <= acc_wr;
                        end else begin
                            ram_ack <= 1'b1;
                        end
                    end
                end
                default: begin
                    phase   <= PH_FIRST;
                    ram_ack <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- soc_pkg.sv
package soc_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    // one ram word or one plic register
    typedef logic [31:0] word_t;
    // source priority or context threshold
    typedef logic [2:0]  prio_t;
    // claim id, 0 means no source
    typedef logic [4:0]  irq_id_t;

    // load/store kinds, stores only use the first four
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    // address map
    localparam addr_t RAM_BASE  = 32'h0000_1000;
    localparam addr_t PLIC_BASE = 32'h0C00_0000;
    localparam addr_t PLIC_SPAN = 32'h0040_0000;

    // plic register offsets inside its window
    localparam addr_t PLIC_PENDING_OFS       = 32'h0000_1000;
    localparam addr_t PLIC_ENABLE_OFS        = 32'h0000_2000;
    localparam addr_t PLIC_CTX_ENABLE_STRIDE = 32'h0000_0080;
    localparam addr_t PLIC_THRESHOLD_OFS     = 32'h0020_0000;
    localparam addr_t PLIC_CLAIM_OFS         = 32'h0020_0004;
    localparam addr_t PLIC_CTX_STRIDE        = 32'h0000_1000;

    // context 0 machine, context 1 supervisor
    localparam int NUM_CONTEXTS = 2;

endpackage
